/* src/lc3b_consts.svh */
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// machine word width in bits
`define LC3B_WIDTH 16

// architectural register count, R0 to R7
`define LC3B_NUM_REGS 8

// address of the first fetch after reset
`define LC3B_RESET_PC 16'h0000

`endif

/* src/lc3b_types.sv */
`include "lc3b_consts.svh"

package lc3b_types;

typedef logic [`LC3B_WIDTH-1:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;     // n, z, p

typedef enum logic [3:0]
{
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_and = 4'b0101,
    op_not = 4'b1001,
    op_shf = 4'b1101,
    op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [2:0]
{
    alu_add,
    alu_and,
    alu_not,
    alu_pass,
    alu_sll,
    alu_srl,
    alu_sra
} lc3b_aluop;

typedef struct packed
{
    lc3b_opcode opcode;
    lc3b_aluop  aluop;
    logic       alumux_sel;       // 0 register, 1 immediate
    logic       imm_sel;          // 0 imm5, 1 shift amount
    logic       addr_base_sel;    // 0 pc+2, 1 base register
    logic       offset_sel;       // 0 offset6, 1 offset9
    logic [1:0] result_sel;       // 0 alu, 1 address, 2 load data
    lc3b_reg    dest;
    logic       load_regfile;
    logic       load_cc;
    logic       mem_read;
    logic       mem_write;
    logic       brmux_sel;        // conditional branch
    lc3b_nzp    nzp;              // branch mask
} lc3b_ctrl;

typedef struct packed
{
    lc3b_ctrl    ctrl;
    lc3b_word    pc_next;
    lc3b_word    src_a;
    lc3b_word    src_b;
    logic [10:0] ir_low;          // offset and immediate bits
} lc3b_ex_payload;

typedef struct packed
{
    lc3b_ctrl ctrl;
    lc3b_word alu_result;
    lc3b_word addr_result;
    lc3b_word store_data;
} lc3b_mem_payload;

typedef struct packed
{
    lc3b_ctrl ctrl;
    lc3b_word result;
} lc3b_wb_payload;

endpackage : lc3b_types

/* src/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg
#(
    parameter type payload_t = logic [15:0],
    parameter payload_t RESET_VALUE = '0
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  payload_t d,
    output payload_t q
);

always_ff @(posedge clk)
begin
    if (rst)
        q <= RESET_VALUE;       // bubble
    else if (load)
        q <= d;
end

endmodule : stage_reg

/* src/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit
(
    input  lc3b_types::lc3b_word instr,
    output lc3b_types::lc3b_reg  src1,
    output lc3b_types::lc3b_reg  src2,
    output lc3b_types::lc3b_ctrl ctrl
);

lc3b_types::lc3b_opcode opcode;

assign opcode = lc3b_types::lc3b_opcode'(instr[15:12]);

always_comb
begin
    ctrl = '0;                              // no writes, no memory access
    ctrl.aluop = lc3b_types::alu_pass;
    ctrl.dest = instr[11:9];
    src1 = instr[8:6];                      // sr1 or base register
    src2 = instr[2:0];

    case (opcode)
        lc3b_types::op_add, lc3b_types::op_and:
        begin
            ctrl.opcode = opcode;
            ctrl.aluop = (opcode == lc3b_types::op_add) ? lc3b_types::alu_add
                                                        : lc3b_types::alu_and;
            ctrl.alumux_sel = instr[5];     // immediate form
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end
        lc3b_types::op_not:
        begin
            ctrl.opcode = opcode;
            ctrl.aluop = lc3b_types::alu_not;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end
        lc3b_types::op_shf:
        begin
            ctrl.opcode = opcode;
            if (!instr[4])
                ctrl.aluop = lc3b_types::alu_sll;
            else if (instr[5])
                ctrl.aluop = lc3b_types::alu_sra;
            else
                ctrl.aluop = lc3b_types::alu_srl;
            ctrl.alumux_sel = 1'b1;
            ctrl.imm_sel = 1'b1;            // imm4 amount
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end
        lc3b_types::op_lea:
        begin
            // LC-3b LEA leaves the condition codes alone
            ctrl.opcode = opcode;
            ctrl.offset_sel = 1'b1;
            ctrl.result_sel = 2'd1;
            ctrl.load_regfile = 1'b1;
        end
        lc3b_types::op_ldr:
        begin
            ctrl.opcode = opcode;
            ctrl.addr_base_sel = 1'b1;
            ctrl.result_sel = 2'd2;
            ctrl.mem_read = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end
        lc3b_types::op_str:
        begin
            ctrl.opcode = opcode;
            ctrl.addr_base_sel = 1'b1;
            ctrl.mem_write = 1'b1;
            src2 = instr[11:9];             // store data register
        end
        lc3b_types::op_br:
        begin
            ctrl.opcode = opcode;
            ctrl.offset_sel = 1'b1;
            ctrl.brmux_sel = 1'b1;
            ctrl.nzp = instr[11:9];         // zero mask never taken
        end
        default:
        begin
            ctrl.brmux_sel = 1'b0;          // unsupported, treated as nop
        end
    endcase
end

endmodule : decode_unit

/* src/regfile.sv */
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module regfile
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

lc3b_types::lc3b_word data [`LC3B_NUM_REGS];

always_ff @(posedge clk)
begin
    if (rst)
    begin
        for (int i = 0; i < `LC3B_NUM_REGS; i++)
            data[i] <= '0;
    end
    else if (load)
    begin
        data[dest] <= in;
    end
end

// read in decode, after the write edge
assign reg_a = data[src_a];
assign reg_b = data[src_b];

endmodule : regfile

/* src/alu.sv */
`timescale 1ns/1ps

module alu
(
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);

logic [3:0] shamt;

assign shamt = b[3:0];          // shift by low nibble

always_comb
begin
    case (aluop)
        lc3b_types::alu_add:
            f = a + b;
        lc3b_types::alu_and:
            f = a & b;
        lc3b_types::alu_not:
            f = ~a;
        lc3b_types::alu_sll:
            f = a << shamt;
        lc3b_types::alu_srl:
            f = a >> shamt;
        lc3b_types::alu_sra:
            f = lc3b_types::lc3b_word'($signed(a) >>> shamt);
        default:
            f = a;              // pass
    endcase
end

endmodule : alu

/* src/addr_unit.sv */
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module addr_unit
(
    input  logic [10:0]          ir_low,
    input  logic                 offset_sel,
    input  logic                 base_sel,
    input  lc3b_types::lc3b_word pc_next,
    input  lc3b_types::lc3b_word base_reg,
    output lc3b_types::lc3b_word addr
);

lc3b_types::lc3b_word sext6;
lc3b_types::lc3b_word sext9;
lc3b_types::lc3b_word offset;
lc3b_types::lc3b_word base;

assign sext6 = {{(`LC3B_WIDTH-6){ir_low[5]}}, ir_low[5:0]};
assign sext9 = {{(`LC3B_WIDTH-9){ir_low[8]}}, ir_low[8:0]};

always_comb
begin
    offset = offset_sel ? sext9 : sext6;
    offset = offset << 1;               // word offset to byte offset
    base = base_sel ? base_reg : pc_next;
end

assign addr = base + offset;

endmodule : addr_unit

/* src/datapath.sv */
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module datapath
(
    input  logic                 clk,
    input  logic                 rst,
    output lc3b_types::lc3b_word instr_address,
    input  lc3b_types::lc3b_word instr_rdata,
    input  logic                 i_mem_resp,
    output lc3b_types::lc3b_word mem_address,
    output logic                 mem_read,
    output logic                 mem_write,
    output lc3b_types::lc3b_word mem_wdata,
    input  lc3b_types::lc3b_word mem_rdata,
    input  logic                 d_mem_resp
);

typedef struct packed
{
    lc3b_types::lc3b_word instr;
    lc3b_types::lc3b_word pc_next;
} fetch_payload;

logic global_load;
logic branch_taken;
lc3b_types::lc3b_word pc;
lc3b_types::lc3b_word pc_plus2;
lc3b_types::lc3b_nzp cc;
lc3b_types::lc3b_nzp gencc;

fetch_payload fetch_d;
fetch_payload dec_q;
lc3b_types::lc3b_reg src1;
lc3b_types::lc3b_reg src2;
lc3b_types::lc3b_word reg_a;
lc3b_types::lc3b_word reg_b;
lc3b_types::lc3b_ctrl dec_ctrl;

lc3b_types::lc3b_ex_payload ex_d;
lc3b_types::lc3b_ex_payload ex_q;
lc3b_types::lc3b_word imm_out;
lc3b_types::lc3b_word alumux_out;
lc3b_types::lc3b_word alu_out;
lc3b_types::lc3b_word addr_out;

lc3b_types::lc3b_mem_payload mem_d;
lc3b_types::lc3b_mem_payload mem_q;
lc3b_types::lc3b_wb_payload wb_d;
lc3b_types::lc3b_wb_payload wb_q;

// every stage steps together once both memories are done
always_comb
begin
    global_load = i_mem_resp & (d_mem_resp | ~(mem_read | mem_write));
end

assign instr_address = pc;
assign pc_plus2 = pc + lc3b_types::lc3b_word'(2);

always_ff @(posedge clk)
begin
    if (rst)
        pc <= `LC3B_RESET_PC;
    else if (global_load)
        pc <= branch_taken ? mem_q.addr_result : pc_plus2;     // redirect from mem stage
end

always_comb
begin
    fetch_d.instr = instr_rdata;
    fetch_d.pc_next = pc_plus2;
end

// all-zero payloads decode as nop
stage_reg #(.payload_t(fetch_payload), .RESET_VALUE('0)) dec_reg
(
    .clk(clk),
    .rst(rst),
    .load(global_load),
    .d(fetch_d),
    .q(dec_q)
);

decode_unit decode
(
    .instr(dec_q.instr),
    .src1(src1),
    .src2(src2),
    .ctrl(dec_ctrl)
);

regfile regs
(
    .clk(clk),
    .rst(rst),
    .load(global_load & wb_q.ctrl.load_regfile),
    .dest(wb_q.ctrl.dest),
    .in(wb_q.result),
    .src_a(src1),
    .src_b(src2),
    .reg_a(reg_a),
    .reg_b(reg_b)
);

always_comb
begin
    ex_d.ctrl = dec_ctrl;
    ex_d.pc_next = dec_q.pc_next;
    ex_d.src_a = reg_a;
    ex_d.src_b = reg_b;
    ex_d.ir_low = dec_q.instr[10:0];
end

stage_reg #(.payload_t(lc3b_types::lc3b_ex_payload), .RESET_VALUE('0)) ex_reg
(
    .clk(clk),
    .rst(rst),
    .load(global_load),
    .d(ex_d),
    .q(ex_q)
);

always_comb
begin
    if (ex_q.ctrl.imm_sel)
        imm_out = {{(`LC3B_WIDTH-4){1'b0}}, ex_q.ir_low[3:0]};             // shift amount
    else
        imm_out = {{(`LC3B_WIDTH-5){ex_q.ir_low[4]}}, ex_q.ir_low[4:0]};   // imm5
    alumux_out = ex_q.ctrl.alumux_sel ? imm_out : ex_q.src_b;
end

alu alu_module
(
    .aluop(ex_q.ctrl.aluop),
    .a(ex_q.src_a),
    .b(alumux_out),
    .f(alu_out)
);

addr_unit addr_module
(
    .ir_low(ex_q.ir_low),
    .offset_sel(ex_q.ctrl.offset_sel),
    .base_sel(ex_q.ctrl.addr_base_sel),
    .pc_next(ex_q.pc_next),
    .base_reg(ex_q.src_a),
    .addr(addr_out)
);

always_comb
begin
    mem_d.ctrl = ex_q.ctrl;
    mem_d.alu_result = alu_out;
    mem_d.addr_result = addr_out;
    mem_d.store_data = ex_q.src_b;
end

stage_reg #(.payload_t(lc3b_types::lc3b_mem_payload), .RESET_VALUE('0)) mem_reg
(
    .clk(clk),
    .rst(rst),
    .load(global_load),
    .d(mem_d),
    .q(mem_q)
);

// request levels held for the whole mem stage
assign mem_read = mem_q.ctrl.mem_read;
assign mem_write = mem_q.ctrl.mem_write;
assign mem_address = mem_q.addr_result;
assign mem_wdata = mem_q.store_data;
assign branch_taken = mem_q.ctrl.brmux_sel & (|(mem_q.ctrl.nzp & cc));

always_comb
begin
    wb_d.ctrl = mem_q.ctrl;
    case (mem_q.ctrl.result_sel)
        2'd1:
            wb_d.result = mem_q.addr_result;
        2'd2:
            wb_d.result = mem_rdata;        // valid when global_load is high
        default:
            wb_d.result = mem_q.alu_result;
    endcase
end

stage_reg #(.payload_t(lc3b_types::lc3b_wb_payload), .RESET_VALUE('0)) wb_reg
(
    .clk(clk),
    .rst(rst),
    .load(global_load),
    .d(wb_d),
    .q(wb_q)
);

always_comb
begin
    if (wb_q.result[`LC3B_WIDTH-1])
        gencc = 3'b100;
    else if (wb_q.result == '0)
        gencc = 3'b010;
    else
        gencc = 3'b001;
end

always_ff @(posedge clk)
begin
    if (rst)
        cc <= 3'b010;                       // registers start at zero
    else if (global_load & wb_q.ctrl.load_cc)
        cc <= gencc;
end

endmodule : datapath

/* bench/datapath_assertions.sv */
`timescale 1ns/1ps

module datapath_assertions
(
    input logic        clk,
    input logic        rst,
    input logic [15:0] instr_address,
    input logic        i_mem_resp,
    input logic        mem_read,
    input logic        mem_write
);

no_dual_request: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else $error("mem_read and mem_write are high together");

// pipeline comes out of reset full of bubbles
idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !mem_read && !mem_write)
    else $error("memory request active in the first cycle after reset");

pc_aligned: assert property (@(posedge clk) disable iff (rst) instr_address[0] == 1'b0)
    else $error("instr_address %h is odd", instr_address);

pc_held: assert property (@(posedge clk) disable iff (rst) !i_mem_resp |=> $stable(instr_address))
    else $error("instr_address moved without an instruction response");    // no response, no advance

endmodule : datapath_assertions

bind datapath datapath_assertions checks
(
    .clk(clk),
    .rst(rst),
    .instr_address(instr_address),
    .i_mem_resp(i_mem_resp),
    .mem_read(mem_read),
    .mem_write(mem_write)
);

/* bench/datapath_tb.sv */
`timescale 1ns/1ps

module datapath_tb;

localparam int NUM_INSTR = 120;
localparam int IMEM_WORDS = 512;
localparam logic [15:0] LOOP_PC = 16'(8 * NUM_INSTR);       // group after the last instruction
localparam int MAX_CYCLES = 4 * (NUM_INSTR + 1) * 5 + 200;

logic clk = 1'b0;
logic rst;
logic [15:0] instr_address;
logic [15:0] instr_rdata;
logic i_mem_resp;
logic [15:0] mem_address;
logic mem_read;
logic mem_write;
logic [15:0] mem_wdata;
logic [15:0] mem_rdata;
logic d_mem_resp;

logic [31:0] lfsr = 32'hfb071085;
logic [15:0] imem [IMEM_WORDS];
logic [15:0] dmem [logic [14:0]];                           // keyed by word address
logic [15:0] model_mem [logic [14:0]];
logic [15:0] m_regs [8];
logic [2:0] m_cc;
logic [15:0] exp_st_addr [$];
logic [15:0] exp_st_data [$];
logic [15:0] exp_ld_addr [$];

logic advanced;
logic d_busy;
int i_wait;
int d_wait;
int cycles;
int loop_hits;
int st_idx;
int ld_idx;
int value_errors;
int other_errors;

datapath uut
(
    .clk(clk),
    .rst(rst),
    .instr_address(instr_address),
    .instr_rdata(instr_rdata),
    .i_mem_resp(i_mem_resp),
    .mem_address(mem_address),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .d_mem_resp(d_mem_resp)
);

always #10 clk = ~clk;

// galois lfsr, one step per bit
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        r = {r[14:0], lfsr[0]};
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return r;
endfunction

function automatic logic [15:0] fill_word(input logic [15:0] addr);
    return {1'b0, addr[15:1]} ^ 16'h5a5a;
endfunction

function automatic logic [15:0] shift_value(input logic [15:0] value, input logic [1:0] kind,
                                            input logic [3:0] amount);
    logic [15:0] result;
    result = value;
    for (int i = 0; i < int'(amount); i++)
    begin
        if (!kind[0])
            result = {result[14:0], 1'b0};                  // left
        else
            result = {kind[1] & result[15], result[15:1]};  // logical or arithmetic right
    end
    return result;
endfunction

task automatic write_reg(input logic [2:0] dr, input logic [15:0] value, input logic set_cc);
    m_regs[dr] = value;
    if (set_cc)
        m_cc = value[15] ? 3'b100 : ((value == 16'h0) ? 3'b010 : 3'b001);
endtask

task automatic build_program();
    logic [3:0] sel;
    logic [2:0] dr;
    logic [2:0] sr1;
    logic [2:0] sr2;
    logic [5:0] imm;
    logic [5:0] alu_src;
    logic flag;
    int skip;
    for (int i = 0; i < IMEM_WORDS; i++)
        imem[i] = 16'h0000;                                 // nop padding everywhere
    for (int g = 0; g < NUM_INSTR; g++)
    begin
        sel = 4'(rand_bits(4));
        dr = 3'(rand_bits(3));
        sr1 = 3'(rand_bits(3));
        sr2 = 3'(rand_bits(3));
        imm = 6'(rand_bits(6));
        flag = 1'(rand_bits(1));
        alu_src = flag ? {1'b1, imm[4:0]} : {3'b000, sr2};
        skip = 1 + int'(imm[1:0]);
        if (skip > NUM_INSTR - g)
            skip = NUM_INSTR - g;                           // never past the final loop
        case (sel)
            4'd0, 4'd1, 4'd2:
                imem[9'(4 * g)] = {4'b0001, dr, sr1, alu_src};
            4'd3, 4'd4:
                imem[9'(4 * g)] = {4'b0101, dr, sr1, alu_src};
            4'd5:
                imem[9'(4 * g)] = {4'b1001, dr, sr1, 6'b111111};
            4'd6, 4'd7:
                imem[9'(4 * g)] = {4'b1101, dr, sr1, imm};
            4'd8:
                imem[9'(4 * g)] = {4'b1110, dr, sr2, imm};
            4'd9, 4'd10:
                imem[9'(4 * g)] = {4'b0110, dr, 1'b0, sr1[1:0], imm};   // low bases overlap more
            4'd11, 4'd12, 4'd13:
                imem[9'(4 * g)] = {4'b0111, dr, 1'b0, sr1[1:0], imm};
            default:
                imem[9'(4 * g)] = {4'b0000, dr, 9'(4 * skip - 1)};     // lands on a group start
        endcase
    end
    imem[9'(4 * NUM_INSTR)] = {4'b0000, 3'b111, 9'h1ff};    // branch to itself
endtask

task automatic run_model();
    logic [15:0] pc;
    logic [15:0] w;
    logic [15:0] src;
    logic [15:0] opnd;
    logic [15:0] addr;
    logic [15:0] off6;
    logic [15:0] off9;
    int steps;
    pc = 16'h0000;
    m_cc = 3'b010;
    steps = 0;
    for (int r = 0; r < 8; r++)
        m_regs[r] = '0;
    while (pc != LOOP_PC && steps < 4 * IMEM_WORDS)
    begin
        w = imem[pc[9:1]];
        src = m_regs[w[8:6]];
        opnd = w[5] ? {{11{w[4]}}, w[4:0]} : m_regs[w[2:0]];
        off6 = {{9{w[5]}}, w[5:0], 1'b0};
        off9 = {{6{w[8]}}, w[8:0], 1'b0};
        pc = pc + 16'd2;
        steps++;
        case (w[15:12])
            4'b0001:
                write_reg(w[11:9], src + opnd, 1'b1);
            4'b0101:
                write_reg(w[11:9], src & opnd, 1'b1);
            4'b1001:
                write_reg(w[11:9], ~src, 1'b1);
            4'b1101:
                write_reg(w[11:9], shift_value(src, w[5:4], w[3:0]), 1'b1);
            4'b1110:
                write_reg(w[11:9], pc + off9, 1'b0);        // lea keeps cc
            4'b0110:
            begin
                addr = src + off6;
                exp_ld_addr.push_back(addr);
                if (model_mem.exists(addr[15:1]))
                    write_reg(w[11:9], model_mem[addr[15:1]], 1'b1);
                else
                    write_reg(w[11:9], fill_word(addr), 1'b1);
            end
            4'b0111:
            begin
                addr = src + off6;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(m_regs[w[11:9]]);
                model_mem[addr[15:1]] = m_regs[w[11:9]];
            end
            default:
            begin
                if ((w[11:9] & m_cc) != 3'b000)             // nop has an empty mask
                    pc = pc + off9;
            end
        endcase
    end
    assert (pc == LOOP_PC)
    else
    begin
        $display("the reference model never reached the final loop");
        other_errors++;
    end
endtask

task automatic compare_word(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected)
    else
    begin
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        value_errors++;
    end
endtask

task automatic compare_count(input string name, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
        $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        value_errors++;
    end
endtask

// mid-cycle, all ports stable
task automatic sample_cycle();
    cycles++;
    advanced = i_mem_resp && (d_mem_resp || !(mem_read || mem_write));
    if (advanced && instr_address == LOOP_PC)
        loop_hits++;
    if (advanced && d_mem_resp && mem_write)
    begin
        assert (st_idx < exp_st_addr.size())
        else
        begin
            $display("store %0d to %h was not expected by the model", st_idx, mem_address);
            other_errors++;
        end
        if (st_idx < exp_st_addr.size())
        begin
            compare_word("store_addr", exp_st_addr[st_idx], mem_address);
            compare_word("store_data", exp_st_data[st_idx], mem_wdata);
        end
        st_idx++;
    end
    if (advanced && d_mem_resp && mem_read)
    begin
        assert (ld_idx < exp_ld_addr.size())
        else
        begin
            $display("load %0d from %h was not expected by the model", ld_idx, mem_address);
            other_errors++;
        end
        if (ld_idx < exp_ld_addr.size())
            compare_word("load_addr", exp_ld_addr[ld_idx], mem_address);
        ld_idx++;
    end
endtask

task automatic drive_memories();
    if (advanced)
    begin
        i_mem_resp = 1'b0;
        i_wait = 1 + int'(rand_bits(2));
    end
    else if (!i_mem_resp)
    begin
        i_wait--;
        if (i_wait == 0)
        begin
            i_mem_resp = 1'b1;
            instr_rdata = imem[instr_address[9:1]];
        end
    end
    if (d_mem_resp)
    begin
        d_mem_resp = 1'b0;                                  // one-cycle pulse
        d_busy = 1'b0;
    end
    if (!d_busy && (mem_read || mem_write))
    begin
        d_busy = 1'b1;
        d_wait = 1 + int'(rand_bits(2)) % 3;
    end
    else if (d_busy)
    begin
        if (d_wait > 1)
            d_wait--;
        else if (i_mem_resp)
        begin
            d_mem_resp = 1'b1;                              // lines up with the advance
            if (mem_write)
                dmem[mem_address[15:1]] = mem_wdata;
            else if (dmem.exists(mem_address[15:1]))
                mem_rdata = dmem[mem_address[15:1]];
            else
                mem_rdata = fill_word(mem_address);
        end
    end
endtask

initial
begin
    rst = 1'b1;
    i_mem_resp = 1'b0;
    instr_rdata = 16'h0000;
    d_mem_resp = 1'b0;
    mem_rdata = 16'h0000;
    advanced = 1'b0;
    d_busy = 1'b0;
    cycles = 0;
    loop_hits = 0;
    st_idx = 0;
    ld_idx = 0;
    value_errors = 0;
    other_errors = 0;
    build_program();
    run_model();
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    i_wait = 1 + int'(rand_bits(2));
    // the loop word must be fetched again after its own redirect
    while (loop_hits < 3 && cycles < MAX_CYCLES)
    begin
        @(negedge clk);
        sample_cycle();
        @(posedge clk);
        #2;
        drive_memories();
    end
    assert (cycles < MAX_CYCLES)
    else
    begin
        $display("timeout: the program did not reach its final loop in %0d cycles", MAX_CYCLES);
        other_errors++;
    end
    compare_count("store_count", exp_st_addr.size(), st_idx);
    compare_count("load_count", exp_ld_addr.size(), ld_idx);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
        $display("STATUS: PASS");
    else
        $display("STATUS: FAIL");
    $finish;
end

endmodule : datapath_tb

/* compile.f */
+incdir+src
src/lc3b_types.sv
src/stage_reg.sv
src/decode_unit.sv
src/regfile.sv
src/alu.sv
src/addr_unit.sv
src/datapath.sv
bench/datapath_assertions.sv
bench/datapath_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= datapath_tb
LOG ?= sim.log
SEED_FLAGS ?= +verilator+seed+1
VFLAGS ?= --binary --timing --assert -Wno-fatal

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f compile.f
	-./obj_dir/V$(TOP) $(SEED_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
